/* design/seq_pkg.sv */
`default_nettype none

package seq_pkg;

   localparam int seq_prog_depth   = 256;
   localparam int seq_num_inputs   = 4;
   localparam int seq_num_channels = 8;

   // instruction field positions
   localparam int seq_op_hi  = 11;
   localparam int seq_op_lo  = 8;
   localparam int seq_imm_hi = 7;
   localparam int seq_imm_lo = 0;
   localparam int seq_src_hi = 5;  // overlaps imm
   localparam int seq_src_lo = 4;
   localparam int seq_cmd_hi = 7;  // overlaps imm
   localparam int seq_cmd_lo = 4;
   localparam int seq_dst_hi = 2;
   localparam int seq_dst_lo = 0;

   typedef logic [11:0]                          seq_inst_t;
   typedef logic [$clog2(seq_prog_depth)-1:0]    seq_addr_t;
   typedef logic [7:0]                           seq_byte_t;
   typedef logic [11:0]                          seq_cmd_t;   // {nibble, transfer}
   typedef logic [seq_num_channels-1:0]          seq_chan_mask_t;

   typedef enum logic [3:0] {
      op_nop = 4'h0,
      op_ldi = 4'h1,
      op_ldr = 4'h2,
      op_cmd = 4'h3,
      op_dmp = 4'h4,
      op_eqi = 4'h5,
      op_eqr = 4'h6,
      op_jxi = 4'h7,
      op_jxr = 4'h8,
      op_jzi = 4'h9,
      op_jzr = 4'ha   // b..f undefined
   } seq_opcode_t;

   typedef enum logic [1:0] {
      state_reset = 2'h0,
      state_ready = 2'h1,
      state_error = 2'h2
   } seq_state_t;

endpackage

`default_nettype wire

/* design/seq_program_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_program_memory (
   input  wire logic               clock,
   input  wire logic               prog_wen,
   input  wire seq_pkg::seq_addr_t prog_addr,
   input  wire seq_pkg::seq_inst_t prog_data,
   input  wire seq_pkg::seq_addr_t fetch_addr,
   output seq_pkg::seq_inst_t      inst
);

   seq_pkg::seq_inst_t mem [seq_pkg::seq_prog_depth];  // host loaded, no reset

   always_ff @(posedge clock) begin
      if (prog_wen) begin
         mem[prog_addr] <= prog_data;
      end
   end

   // same-cycle fetch for the core
   assign inst = mem[fetch_addr];

endmodule

`default_nettype wire

/* design/seq_core.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_core (
   input  wire logic               clock,
   input  wire logic               reset,
   input  wire seq_pkg::seq_inst_t inst,
   input  wire logic               inst_en,
   input  wire seq_pkg::seq_byte_t ireg_0,
   input  wire seq_pkg::seq_byte_t ireg_1,
   input  wire seq_pkg::seq_byte_t ireg_2,
   input  wire seq_pkg::seq_byte_t ireg_3,
   output seq_pkg::seq_addr_t      next,
   output seq_pkg::seq_cmd_t       oreg,
   output seq_pkg::seq_chan_mask_t oreg_wen,
   output logic                    error
);

   seq_pkg::seq_state_t     c_state;
   seq_pkg::seq_state_t     n_state;
   seq_pkg::seq_byte_t      c_transfer;
   seq_pkg::seq_byte_t      n_transfer;
   seq_pkg::seq_addr_t      c_addr;
   seq_pkg::seq_addr_t      n_addr;
   seq_pkg::seq_addr_t      step_addr;

   seq_pkg::seq_opcode_t    opcode;
   seq_pkg::seq_byte_t      imm;
   logic [$clog2(seq_pkg::seq_num_inputs)-1:0]   src;
   logic [3:0]              cmd;
   logic [$clog2(seq_pkg::seq_num_channels)-1:0] dst;

   seq_pkg::seq_byte_t      ireg [seq_pkg::seq_num_inputs];
   seq_pkg::seq_byte_t      ireg_mux;
   seq_pkg::seq_chan_mask_t dst_mask;
   logic                    transfer_zero;

   // field decode
   assign opcode = seq_pkg::seq_opcode_t'(inst[seq_pkg::seq_op_hi:seq_pkg::seq_op_lo]);
   assign imm    = inst[seq_pkg::seq_imm_hi:seq_pkg::seq_imm_lo];
   assign src    = inst[seq_pkg::seq_src_hi:seq_pkg::seq_src_lo];
   assign cmd    = inst[seq_pkg::seq_cmd_hi:seq_pkg::seq_cmd_lo];
   assign dst    = inst[seq_pkg::seq_dst_hi:seq_pkg::seq_dst_lo];

   assign ireg          = '{ireg_0, ireg_1, ireg_2, ireg_3};
   assign ireg_mux      = ireg[src];
   assign dst_mask      = seq_pkg::seq_chan_mask_t'(1) << dst;  // one-hot channel
   assign step_addr     = c_addr + 8'd1;  // wraps 255 -> 0
   assign transfer_zero = (c_transfer == 8'd0);

   assign next  = c_addr;
   assign error = (c_state == seq_pkg::state_error);

   always_comb begin
      n_state    = c_state;
      n_transfer = c_transfer;
      n_addr     = c_addr;
      oreg       = '0;
      oreg_wen   = '0;
      case (c_state)
         seq_pkg::state_reset: begin
            n_state    = seq_pkg::state_ready;
            n_transfer = '0;
            n_addr     = '0;
         end

         seq_pkg::state_ready: begin
            if (inst_en) begin
               n_addr = step_addr;  // overridden by taken jumps
               case (opcode)
                  seq_pkg::op_nop: begin
                     n_transfer = c_transfer;
                  end
                  seq_pkg::op_ldi: begin
                     n_transfer = imm;
                  end
                  seq_pkg::op_ldr: begin
                     n_transfer = ireg_mux;
                  end
                  seq_pkg::op_cmd: begin
                     oreg     = {cmd, c_transfer};
                     oreg_wen = dst_mask;
                  end
                  seq_pkg::op_dmp: begin
                     oreg     = {4'b0000, c_transfer};
                     oreg_wen = dst_mask;
                  end
                  seq_pkg::op_eqi: begin
                     n_transfer = (c_transfer == imm) ? 8'd1 : 8'd0;
                  end
                  seq_pkg::op_eqr: begin
                     n_transfer = (c_transfer == ireg_mux) ? 8'd1 : 8'd0;
                  end
                  seq_pkg::op_jxi: begin
                     n_addr = imm;
                  end
                  seq_pkg::op_jxr: begin
                     n_addr = ireg_mux;
                  end
                  seq_pkg::op_jzi: begin
                     if (transfer_zero) begin
                        n_addr = imm;
                     end
                  end
                  seq_pkg::op_jzr: begin
                     if (transfer_zero) begin
                        n_addr = ireg_mux;
                     end
                  end
                  default: begin  // undefined opcode
                     n_state    = seq_pkg::state_error;
                     n_transfer = '0;
                     n_addr     = '0;
                  end
               endcase
            end
         end

         seq_pkg::state_error: begin  // sticky until reset
            n_transfer = '0;
            n_addr     = '0;
         end

         default: begin
            n_state    = seq_pkg::state_error;
            n_transfer = '0;
            n_addr     = '0;
         end
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         c_state    <= seq_pkg::state_reset;
         c_transfer <= '0;
         c_addr     <= '0;
      end else begin
         c_state    <= n_state;
         c_transfer <= n_transfer;
         c_addr     <= n_addr;
      end
   end

   a_wen_onehot0: assert property (
      @(posedge clock) disable iff (reset) $onehot0(oreg_wen)
   ) else $error("oreg_wen has more than one channel set");

   a_error_no_write: assert property (
      @(posedge clock) disable iff (reset) error |-> (oreg_wen == '0)
   ) else $error("channel write while in error state");

   a_error_pc_zero: assert property (
      @(posedge clock) disable iff (reset) error |-> (next == '0)
   ) else $error("pc not zero in error state");

endmodule

`default_nettype wire

/* design/seq_command_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_command_bank (
   input  wire logic                    clock,
   input  wire logic                    reset,
   input  wire seq_pkg::seq_cmd_t       oreg,
   input  wire seq_pkg::seq_chan_mask_t oreg_wen,
   output seq_pkg::seq_cmd_t            chan_0,
   output seq_pkg::seq_cmd_t            chan_1,
   output seq_pkg::seq_cmd_t            chan_2,
   output seq_pkg::seq_cmd_t            chan_3,
   output seq_pkg::seq_cmd_t            chan_4,
   output seq_pkg::seq_cmd_t            chan_5,
   output seq_pkg::seq_cmd_t            chan_6,
   output seq_pkg::seq_cmd_t            chan_7,
   output seq_pkg::seq_chan_mask_t      chan_strobe
);

   seq_pkg::seq_cmd_t chan_q [seq_pkg::seq_num_channels];

   always_ff @(posedge clock) begin
      if (reset) begin
         chan_strobe <= '0;
         for (int i = 0; i < seq_pkg::seq_num_channels; i++) begin
            chan_q[i] <= '0;
         end
      end else begin
         chan_strobe <= oreg_wen;  // one cycle pulse per write
         for (int i = 0; i < seq_pkg::seq_num_channels; i++) begin
            if (oreg_wen[i]) begin
               chan_q[i] <= oreg;
            end
         end
      end
   end

   assign chan_0 = chan_q[0];
   assign chan_1 = chan_q[1];
   assign chan_2 = chan_q[2];
   assign chan_3 = chan_q[3];
   assign chan_4 = chan_q[4];
   assign chan_5 = chan_q[5];
   assign chan_6 = chan_q[6];
   assign chan_7 = chan_q[7];

   // strobes mirror the core's one-hot write mask, one step late
   a_strobe_onehot0: assert property (
      @(posedge clock) disable iff (reset) $onehot0(chan_strobe)
   ) else $error("more than one channel strobe active");

endmodule

`default_nettype wire

/* design/seq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_top (
   input  wire logic               clock,
   input  wire logic               reset,
   input  wire logic               run,
   input  wire logic               prog_wen,
   input  wire seq_pkg::seq_addr_t prog_addr,
   input  wire seq_pkg::seq_inst_t prog_data,
   input  wire seq_pkg::seq_byte_t ireg_0,
   input  wire seq_pkg::seq_byte_t ireg_1,
   input  wire seq_pkg::seq_byte_t ireg_2,
   input  wire seq_pkg::seq_byte_t ireg_3,
   output seq_pkg::seq_addr_t      pc,
   output logic                    error,
   output seq_pkg::seq_cmd_t       chan_0,
   output seq_pkg::seq_cmd_t       chan_1,
   output seq_pkg::seq_cmd_t       chan_2,
   output seq_pkg::seq_cmd_t       chan_3,
   output seq_pkg::seq_cmd_t       chan_4,
   output seq_pkg::seq_cmd_t       chan_5,
   output seq_pkg::seq_cmd_t       chan_6,
   output seq_pkg::seq_cmd_t       chan_7,
   output seq_pkg::seq_chan_mask_t chan_strobe
);

   logic                    inst_en;
   seq_pkg::seq_inst_t      inst;
   seq_pkg::seq_cmd_t       oreg;
   seq_pkg::seq_chan_mask_t oreg_wen;

   assign inst_en = run & ~prog_wen;  // no execution during host writes

   seq_program_memory seq_program_memory_inst (
      .clock      (clock),
      .prog_wen   (prog_wen),
      .prog_addr  (prog_addr),
      .prog_data  (prog_data),
      .fetch_addr (pc),
      .inst       (inst)
   );

   seq_core seq_core_inst (
      .clock    (clock),
      .reset    (reset),
      .inst     (inst),
      .inst_en  (inst_en),
      .ireg_0   (ireg_0),
      .ireg_1   (ireg_1),
      .ireg_2   (ireg_2),
      .ireg_3   (ireg_3),
      .next     (pc),
      .oreg     (oreg),
      .oreg_wen (oreg_wen),
      .error    (error)
   );

   seq_command_bank seq_command_bank_inst (
      .clock       (clock),
      .reset       (reset),
      .oreg        (oreg),
      .oreg_wen    (oreg_wen),
      .chan_0      (chan_0),
      .chan_1      (chan_1),
      .chan_2      (chan_2),
      .chan_3      (chan_3),
      .chan_4      (chan_4),
      .chan_5      (chan_5),
      .chan_6      (chan_6),
      .chan_7      (chan_7),
      .chan_strobe (chan_strobe)
   );

endmodule

`default_nettype wire

/* tests/seq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_tb;

   logic                    clock;
   logic                    reset;
   logic                    run;
   logic                    prog_wen;
   seq_pkg::seq_addr_t      prog_addr;
   seq_pkg::seq_inst_t      prog_data;
   seq_pkg::seq_byte_t      ireg_0;
   seq_pkg::seq_byte_t      ireg_1;
   seq_pkg::seq_byte_t      ireg_2;
   seq_pkg::seq_byte_t      ireg_3;
   seq_pkg::seq_addr_t      pc;
   logic                    error;
   seq_pkg::seq_cmd_t       chan_0, chan_1, chan_2, chan_3;
   seq_pkg::seq_cmd_t       chan_4, chan_5, chan_6, chan_7;
   seq_pkg::seq_chan_mask_t chan_strobe;
   seq_pkg::seq_cmd_t       dut_chan [8];

   // software copy of the sequencer
   seq_pkg::seq_inst_t      m_prog [256];
   seq_pkg::seq_state_t     m_state;
   seq_pkg::seq_addr_t      m_pc;
   seq_pkg::seq_byte_t      m_xfer;
   seq_pkg::seq_cmd_t       m_chan [8];
   seq_pkg::seq_chan_mask_t m_strobe;
   logic                    started;
   logic [31:0]             rng_state;

   seq_top seq_top_inst (
      .clock (clock), .reset (reset), .run (run),
      .prog_wen (prog_wen), .prog_addr (prog_addr), .prog_data (prog_data),
      .ireg_0 (ireg_0), .ireg_1 (ireg_1), .ireg_2 (ireg_2), .ireg_3 (ireg_3),
      .pc (pc), .error (error),
      .chan_0 (chan_0), .chan_1 (chan_1), .chan_2 (chan_2), .chan_3 (chan_3),
      .chan_4 (chan_4), .chan_5 (chan_5), .chan_6 (chan_6), .chan_7 (chan_7),
      .chan_strobe (chan_strobe)
   );

   assign dut_chan = '{chan_0, chan_1, chan_2, chan_3, chan_4, chan_5, chan_6, chan_7};

   initial begin
      clock = 1'b0;
      forever #20 clock = ~clock;
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] s;
      s = rng_state;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      rng_state = s;
      return s;
   endfunction

   // one instruction of the sequencer, as the instruction set defines it
   function automatic void ref_step(
      input  seq_pkg::seq_inst_t      word,
      input  seq_pkg::seq_addr_t      pc_in,
      input  seq_pkg::seq_byte_t      xfer_in,
      input  seq_pkg::seq_byte_t      r0, r1, r2, r3,
      output seq_pkg::seq_addr_t      pc_out,
      output seq_pkg::seq_byte_t      xfer_out,
      output seq_pkg::seq_cmd_t       cmd_out,
      output seq_pkg::seq_chan_mask_t wen_out,
      output logic                    illegal
   );
      logic [3:0]         op;
      seq_pkg::seq_byte_t imm;
      seq_pkg::seq_byte_t sel;
      logic [2:0]         dst;
      op  = word[11:8];
      imm = word[7:0];
      dst = word[2:0];
      case (word[5:4])
         2'd0:    sel = r0;
         2'd1:    sel = r1;
         2'd2:    sel = r2;
         default: sel = r3;
      endcase
      pc_out   = pc_in + 8'd1;
      xfer_out = xfer_in;
      cmd_out  = '0;
      wen_out  = '0;
      illegal  = 1'b0;
      case (op)
         seq_pkg::op_nop: ;
         seq_pkg::op_ldi: xfer_out = imm;
         seq_pkg::op_ldr: xfer_out = sel;
         seq_pkg::op_cmd: begin
            cmd_out = {word[7:4], xfer_in};
            wen_out = 8'd1 << dst;
         end
         seq_pkg::op_dmp: begin
            cmd_out = {4'h0, xfer_in};
            wen_out = 8'd1 << dst;
         end
         seq_pkg::op_eqi: xfer_out = (xfer_in == imm) ? 8'd1 : 8'd0;
         seq_pkg::op_eqr: xfer_out = (xfer_in == sel) ? 8'd1 : 8'd0;
         seq_pkg::op_jxi: pc_out = imm;
         seq_pkg::op_jxr: pc_out = sel;
         seq_pkg::op_jzi: if (xfer_in == 8'd0) pc_out = imm;
         seq_pkg::op_jzr: if (xfer_in == 8'd0) pc_out = sel;
         default: illegal = 1'b1;
      endcase
   endfunction

   always @(posedge clock) begin
      seq_pkg::seq_addr_t      npc;
      seq_pkg::seq_byte_t      nxfer;
      seq_pkg::seq_cmd_t       word;
      seq_pkg::seq_chan_mask_t wen;
      logic                    bad;
      m_strobe = '0;
      if (reset) begin
         m_state = seq_pkg::state_reset;
         m_pc    = '0;
         m_xfer  = '0;
         for (int i = 0; i < 8; i++) m_chan[i] = '0;
      end else if (m_state == seq_pkg::state_reset) begin
         m_state = seq_pkg::state_ready;
      end else if (m_state == seq_pkg::state_ready && run && !prog_wen) begin
         ref_step(m_prog[m_pc], m_pc, m_xfer, ireg_0, ireg_1, ireg_2, ireg_3,
                  npc, nxfer, word, wen, bad);
         if (bad) begin
            m_state = seq_pkg::state_error;
            m_pc    = '0;
            m_xfer  = '0;
         end else begin
            m_pc     = npc;
            m_xfer   = nxfer;
            m_strobe = wen;
            for (int i = 0; i < 8; i++) if (wen[i]) m_chan[i] = word;
         end
      end
      if (prog_wen) m_prog[prog_addr] = prog_data;  // host write
      started = 1'b1;
   end

   task automatic report_fail();
      $display("tests failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_addr(input string name, input seq_pkg::seq_addr_t exp,
                             input seq_pkg::seq_addr_t act);
      if (act !== exp) begin
         $display("Mismatch %s expected %h actual %h", name, exp, act);
         report_fail();
      end
   endtask

   task automatic check_cmd(input string name, input seq_pkg::seq_cmd_t exp,
                            input seq_pkg::seq_cmd_t act);
      if (act !== exp) begin
         $display("Mismatch %s expected %h actual %h", name, exp, act);
         report_fail();
      end
   endtask

   task automatic check_mask(input string name, input seq_pkg::seq_chan_mask_t exp,
                             input seq_pkg::seq_chan_mask_t act);
      if (act !== exp) begin
         $display("Mismatch %s expected %h actual %h", name, exp, act);
         report_fail();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Mismatch %s expected %h actual %h", name, exp, act);
         report_fail();
      end
   endtask

   // outputs are registered, stable at the falling edge
   always @(negedge clock) begin
      if (started) begin
         check_addr("pc", m_pc, pc);
         check_flag("error", m_state == seq_pkg::state_error, error);
         for (int i = 0; i < 8; i++) begin
            check_cmd($sformatf("chan_%0d", i), m_chan[i], dut_chan[i]);
         end
         check_mask("chan_strobe", m_strobe, chan_strobe);
      end
   end

   task automatic apply_reset();
      @(negedge clock);
      reset = 1'b1;
      repeat (5) @(negedge clock);
      reset = 1'b0;
   endtask

   task automatic write_word(input seq_pkg::seq_addr_t addr, input seq_pkg::seq_inst_t data);
      @(negedge clock);
      prog_wen  = 1'b1;
      prog_addr = addr;
      prog_data = data;
      @(negedge clock);
      prog_wen  = 1'b0;
   endtask

   task automatic wait_pc(input seq_pkg::seq_addr_t target, input int limit);
      int  n;
      logic hit;
      n   = 0;
      hit = 1'b0;
      while (!hit && n < limit) begin
         @(negedge clock);
         hit = (pc === target);
         n++;
      end
      if (!hit) begin
         $display("timeout waiting for pc to reach %h", target);
         report_fail();
      end
   endtask

   task automatic wait_error(input int limit);
      int  n;
      n = 0;
      while (error !== 1'b1 && n < limit) begin
         @(negedge clock);
         n++;
      end
      if (error !== 1'b1) begin
         $display("timeout waiting for the error flag to rise");
         report_fail();
      end
   endtask

   function automatic seq_pkg::seq_inst_t mk_imm(input logic [3:0] op, input logic [7:0] imm);
      return {op, imm};
   endfunction

   function automatic seq_pkg::seq_inst_t mk_reg(input logic [3:0] op, input logic [1:0] src);
      return {op, 2'b00, src, 4'h0};
   endfunction

   function automatic seq_pkg::seq_inst_t mk_out(input logic [3:0] op, input logic [3:0] nib,
                                                 input logic [2:0] dst);
      return {op, nib, 1'b0, dst};
   endfunction

   initial begin
      logic [31:0] r;
      started   = 1'b0;
      rng_state = 32'd70;
      reset     = 1'b1;
      run       = 1'b0;
      prog_wen  = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      ireg_0    = '0;
      ireg_1    = '0;
      ireg_2    = '0;
      ireg_3    = '0;

      // reset
      apply_reset();
      @(negedge clock);
      check_addr("pc", 8'h00, pc);
      check_flag("error", 1'b0, error);
      check_mask("chan_strobe", 8'h00, chan_strobe);
      for (int i = 0; i < 8; i++) check_cmd($sformatf("chan_%0d", i), 12'h000, dut_chan[i]);

      // loads and output writes
      ireg_1 = 8'hc3;
      write_word(8'h00, mk_imm(4'h1, 8'h5a));
      write_word(8'h01, mk_out(4'h3, 4'h3, 3'd2));
      write_word(8'h02, mk_reg(4'h2, 2'd1));
      write_word(8'h03, mk_out(4'h4, 4'h0, 3'd5));
      write_word(8'h04, mk_imm(4'h7, 8'h04));  // park loop
      run = 1'b1;
      wait_pc(8'h04, 20);
      repeat (3) @(negedge clock);
      check_cmd("chan_2", 12'h35a, chan_2);
      check_cmd("chan_5", 12'h0c3, chan_5);

      // compares and jumps
      run = 1'b0;
      ireg_0 = 8'h77;
      ireg_1 = 8'hfe;
      ireg_2 = 8'h00;
      ireg_3 = 8'h30;
      write_word(8'h00, mk_imm(4'h1, 8'h00));
      write_word(8'h01, mk_imm(4'h9, 8'h10));  // taken
      write_word(8'h10, mk_imm(4'h5, 8'h00));
      write_word(8'h11, mk_imm(4'h9, 8'h20));  // not taken
      write_word(8'h12, mk_reg(4'h2, 2'd2));
      write_word(8'h13, mk_reg(4'ha, 2'd3));
      write_word(8'h30, mk_reg(4'h6, 2'd0));
      write_word(8'h31, mk_reg(4'h8, 2'd1));
      write_word(8'hfe, mk_out(4'h3, 4'h6, 3'd6));  // channel write inside the loop
      write_word(8'hff, mk_imm(4'h0, 8'h00));
      apply_reset();
      run = 1'b1;
      wait_pc(8'h30, 20);
      wait_pc(8'hff, 20);
      wait_pc(8'h00, 5);  // wrap
      wait_pc(8'h30, 20);

      // run gating with host write pulses
      for (int n = 0; n < 300; n++) begin
         @(negedge clock);
         r         = next_rand();
         run       = r[0];
         prog_wen  = (r[7:4] == 4'h0);
         prog_addr = 8'h80 + seq_pkg::seq_addr_t'(r[11:8]);
         prog_data = mk_imm(4'h0, r[23:16]);
      end
      @(negedge clock);
      prog_wen = 1'b0;
      run      = 1'b1;
      wait_pc(8'h30, 40);

      // illegal opcode
      run = 1'b0;
      write_word(8'h00, mk_imm(4'h1, 8'h11));
      write_word(8'h01, mk_out(4'h3, 4'h9, 3'd1));
      write_word(8'h02, 12'hb00);
      write_word(8'h03, mk_out(4'h3, 4'h5, 3'd3));
      apply_reset();
      run = 1'b1;
      wait_error(20);
      check_addr("pc", 8'h00, pc);
      repeat (20) @(negedge clock);
      check_cmd("chan_1", 12'h911, chan_1);
      check_cmd("chan_3", 12'h000, chan_3);
      check_flag("error", 1'b1, error);
      apply_reset();
      @(negedge clock);
      check_flag("error", 1'b0, error);
      wait_pc(8'h02, 20);
      wait_error(5);

      // random programs
      run = 1'b0;
      for (int a = 0; a < 256; a++) begin
         r = next_rand();
         write_word(seq_pkg::seq_addr_t'(a), {4'(r[15:8] % 11), r[7:0]});
      end
      apply_reset();
      for (int n = 0; n < 2000; n++) begin
         @(negedge clock);
         r      = next_rand();
         run    = (r[2:0] != 3'd0);
         ireg_0 = r[15:8];
         ireg_1 = r[23:16];
         ireg_2 = r[31:24];
         ireg_3 = seq_pkg::seq_byte_t'(next_rand());
      end

      repeat (2) @(negedge clock);
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
design/seq_pkg.sv
design/seq_program_memory.sv
design/seq_core.sv
design/seq_command_bank.sv
design/seq_top.sv
tests/seq_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sequencer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f \
   --top-module seq_tb \
   --Mdir build \
   -o seq_sim

./build/seq_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
   exit 0
else
   echo "simulation did not pass, see sim.log"
   exit 1
fi
